/* include/jsp_defines.svh */
`ifndef JSP_DEFINES_SVH
`define JSP_DEFINES_SVH

// Byte slots in each direction
`define JSP_FIFO_DEPTH 8

// Wide enough for 0 up to a full FIFO
`define JSP_COUNT_W 4

// Eight byte-wide registers on APB
`define JSP_ADDR_W 3

`endif

/* logic/jsp_link_pkg.sv */
`default_nettype none

`include "jsp_defines.svh"

package jsp_link_pkg;

  //////////////////////////////
  // JTAG side byte link
  //////////////////////////////

  // One data byte as it moves between JTAG and APB
  typedef logic [7:0] byte_t;

  // Fill level or free space of a byte FIFO
  typedef logic [`JSP_COUNT_W-1:0] count_t;

endpackage : jsp_link_pkg

`default_nettype wire

/* logic/jsp_bus_pkg.sv */
`default_nettype none

`include "jsp_defines.svh"

package jsp_bus_pkg;

  //////////////////////////////
  // 16550 style register map
  //////////////////////////////

  // Word offsets on paddr
  typedef enum logic [`JSP_ADDR_W-1:0] {
    REG_DATA    = 3'd0,
    REG_IER     = 3'd1,
    REG_IIR_FCR = 3'd2,
    REG_LCR     = 3'd3,
    REG_MCR     = 3'd4,
    REG_LSR     = 3'd5,
    REG_MSR     = 3'd6,
    REG_SCR     = 3'd7
  } reg_addr_e;

  // Interrupt identification codes in priority order
  typedef enum logic [7:0] {
    IIR_RX_DATA   = 8'h04,
    IIR_THR_EMPTY = 8'h02,
    IIR_NONE      = 8'h01
  } iir_code_e;

  // Modem lines are not modelled
  localparam logic [7:0] MCR_VALUE = 8'h00;
  localparam logic [7:0] MSR_VALUE = 8'h0B;

  // Divisor latch access bit in LCR
  localparam int unsigned LCR_DLAB = 7;

  // FIFO flush bits in FCR
  localparam int unsigned FCR_RX_FLUSH = 1;
  localparam int unsigned FCR_TX_FLUSH = 2;

endpackage : jsp_bus_pkg

`default_nettype wire

/* logic/jsp_byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jsp_defines.svh"

module jsp_byte_fifo
  import jsp_link_pkg::*;
(
  input  wire        PCLK,
  input  wire        PRESETn,
  input  wire        flush_i,
  input  wire        en_i,
  input  wire        push_i,
  input  wire byte_t data_i,
  output byte_t      data_o,
  output count_t     avail_o,
  output count_t     free_o
);

  localparam int unsigned PTR_W = $clog2(`JSP_FIFO_DEPTH);

  byte_t            mem [`JSP_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  count_t           cnt;
  logic             do_push;
  logic             do_pop;

  // Full and empty silently drop the access
  assign do_push = en_i & push_i & (cnt != count_t'(`JSP_FIFO_DEPTH));
  assign do_pop  = en_i & ~push_i & (cnt != '0);

  // Pointers wrap by themselves since the depth is a power of two
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
      cnt    <= cnt + 1'b1;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
      cnt    <= cnt - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge PCLK) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Head of queue is visible without a pop
  assign data_o  = mem[rd_ptr];
  assign avail_o = cnt;
  assign free_o  = count_t'(`JSP_FIFO_DEPTH) - cnt;

  // Every slot is counted once as filled or free
  a_slots_accounted : assert property (@(posedge PCLK) disable iff (!PRESETn)
    (int'(avail_o) + int'(free_o)) == `JSP_FIFO_DEPTH);

endmodule : jsp_byte_fifo

`default_nettype wire

/* logic/jsp_strobe_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module jsp_strobe_sync (
  input  wire  PCLK,
  input  wire  PRESETn,
  input  wire  toggle_i,
  input  wire  clear_i,
  output logic level_o
);

  logic sync_q1;
  logic sync_q2;
  logic sync_q3;
  logic pend_q;
  logic edge_w;

  // Two stage synchronizer plus one stage to find the edge
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      sync_q3 <= 1'b0;
      pend_q  <= 1'b0;
    end else begin
      sync_q1 <= toggle_i;
      sync_q2 <= sync_q1;
      sync_q3 <= sync_q2;
      // A new edge beats a clear in the same cycle
      pend_q  <= edge_w | (pend_q & ~clear_i);
    end
  end

  assign edge_w = sync_q2 ^ sync_q3;

  // Edge shows up one cycle early so the consumer can react sooner
  assign level_o = pend_q | edge_w;

endmodule : jsp_strobe_sync

`default_nettype wire

/* logic/jsp_count_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module jsp_count_sync
  import jsp_link_pkg::*;
#(
  parameter count_t RESET_COUNT = '0
) (
  input  wire         PCLK,
  input  wire         PRESETn,
  input  wire         tck_i,
  input  wire count_t count_i,
  output count_t      count_o
);

  count_t hold_q;
  logic   req_tog_q;
  logic   ack_s1;
  logic   ack_s2;
  logic   busy;
  logic   req_s1;
  logic   req_s2;
  logic   req_s3;
  logic   ack_tog_q;

  //////////////////////////////
  // PCLK side
  //////////////////////////////

  // A handshake is in flight until the ack toggle comes back
  assign busy = req_tog_q ^ ack_s2;

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      req_tog_q <= 1'b0;
      ack_s1    <= 1'b0;
      ack_s2    <= 1'b0;
    end else begin
      ack_s1 <= ack_tog_q;
      ack_s2 <= ack_s1;
      if (!busy) begin
        req_tog_q <= ~req_tog_q;
      end
    end
  end

  // Held stable for the whole handshake
  always_ff @(posedge PCLK) begin
    if (!busy) begin
      hold_q <= count_i;
    end
  end

  //////////////////////////////
  // tck side
  //////////////////////////////

  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      req_s1    <= 1'b0;
      req_s2    <= 1'b0;
      req_s3    <= 1'b0;
      ack_tog_q <= 1'b0;
      count_o   <= RESET_COUNT;
    end else begin
      req_s1 <= req_tog_q;
      req_s2 <= req_s1;
      req_s3 <= req_s2;
      // Request edge means hold_q has settled
      if (req_s2 ^ req_s3) begin
        count_o   <= hold_q;
        ack_tog_q <= req_s2;
      end
    end
  end

endmodule : jsp_count_sync

`default_nettype wire

/* logic/jsp_host_rx_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jsp_defines.svh"

module jsp_host_rx_path
  import jsp_link_pkg::*;
(
  input  wire        PCLK,
  input  wire        PRESETn,
  input  wire        tck_i,
  input  wire        wr_strobe_i,
  input  wire byte_t data_i,
  input  wire        pop_req_i,
  input  wire        flush_i,
  output logic       ack_o,
  output byte_t      rx_data_o,
  output count_t     rx_count_o,
  output count_t     bytes_free_o
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PUSH,
    RX_POP
  } rx_state_e;

  rx_state_e state_q;
  rx_state_e state_d;
  byte_t     wdata_q;
  logic      wen_tog_q;
  logic      wdata_avail;
  logic      push_now;
  logic      fifo_en;
  count_t    fifo_free;

  //////////////////////////////
  // tck side capture
  //////////////////////////////

  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      wen_tog_q <= 1'b0;
    end else if (wr_strobe_i) begin
      wen_tog_q <= ~wen_tog_q;
    end
  end

  // Byte stays put until the next strobe
  always_ff @(posedge tck_i) begin
    if (wr_strobe_i) begin
      wdata_q <= data_i;
    end
  end

  //////////////////////////////
  // PCLK side sequencer
  //////////////////////////////

  jsp_strobe_sync u_wen_sync (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .toggle_i (wen_tog_q),
    .clear_i  (push_now),
    .level_o  (wdata_avail)
  );

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      state_q <= RX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // APB pop wins over a waiting JTAG byte
  always_comb begin
    state_d = RX_IDLE;
    case (state_q)
      RX_IDLE: begin
        if (pop_req_i) begin
          state_d = RX_POP;
        end else if (wdata_avail) begin
          state_d = RX_PUSH;
        end
      end
      RX_PUSH: begin
        // Pending level is being cleared here so it is not looked at
        if (pop_req_i) begin
          state_d = RX_POP;
        end
      end
      RX_POP: begin
        if (wdata_avail) begin
          state_d = RX_PUSH;
        end
      end
      default: begin
        state_d = RX_IDLE;
      end
    endcase
  end

  assign push_now = (state_q == RX_PUSH);
  assign fifo_en  = (state_q != RX_IDLE);
  assign ack_o    = (state_q == RX_POP);

  jsp_byte_fifo u_rx_fifo (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .flush_i  (flush_i),
    .en_i     (fifo_en),
    .push_i   (push_now),
    .data_i   (wdata_q),
    .data_o   (rx_data_o),
    .avail_o  (rx_count_o),
    .free_o   (fifo_free)
  );

  // Free space back to the debug unit
  jsp_count_sync #(
    .RESET_COUNT (count_t'(`JSP_FIFO_DEPTH))
  ) u_free_sync (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .tck_i    (tck_i),
    .count_i  (fifo_free),
    .count_o  (bytes_free_o)
  );

  // A request that lands while a pop is being acked would be lost
  a_no_req_during_ack : assert property (@(posedge PCLK) disable iff (!PRESETn)
    pop_req_i |-> !ack_o);

endmodule : jsp_host_rx_path

`default_nettype wire

/* logic/jsp_host_tx_path.sv */
`timescale 1ns/1ps
`default_nettype none

module jsp_host_tx_path
  import jsp_link_pkg::*;
(
  input  wire        PCLK,
  input  wire        PRESETn,
  input  wire        tck_i,
  input  wire        rd_strobe_i,
  input  wire        push_req_i,
  input  wire byte_t pwdata_i,
  input  wire        flush_i,
  output logic       ack_o,
  output count_t     tx_count_o,
  output logic       tx_popped_last_o,
  output byte_t      data_o,
  output count_t     bytes_available_o
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_PUSH,
    TX_POP,
    TX_LATCH
  } tx_state_e;

  tx_state_e state_q;
  tx_state_e state_d;
  logic      ren_tog_q;
  logic      rd_pending;
  logic      push_pend_q;
  logic      push_now;
  logic      pop_now;
  byte_t     wdata_q;
  byte_t     fifo_head;

  // JTAG read strobe as a toggle
  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      ren_tog_q <= 1'b0;
    end else if (rd_strobe_i) begin
      ren_tog_q <= ~ren_tog_q;
    end
  end

  jsp_strobe_sync u_ren_sync (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .toggle_i (ren_tog_q),
    .clear_i  (pop_now),
    .level_o  (rd_pending)
  );

  //////////////////////////////
  // APB write capture
  //////////////////////////////

  // Ack right away and keep the byte until the sequencer gets to it
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      ack_o       <= 1'b0;
      push_pend_q <= 1'b0;
    end else begin
      ack_o       <= push_req_i;
      push_pend_q <= push_req_i | (push_pend_q & ~push_now);
    end
  end

  always_ff @(posedge PCLK) begin
    if (push_req_i) begin
      wdata_q <= pwdata_i;
    end
  end

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      state_q <= TX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = TX_IDLE;
    case (state_q)
      TX_IDLE, TX_LATCH: begin
        if (push_req_i || push_pend_q) begin
          state_d = TX_PUSH;
        end else if (rd_pending) begin
          state_d = TX_POP;
        end
      end
      TX_PUSH: begin
        // First byte into an empty FIFO becomes the new head
        if (tx_count_o == '0) begin
          state_d = TX_LATCH;
        end else if (push_req_i) begin
          state_d = TX_PUSH;
        end else if (rd_pending) begin
          state_d = TX_POP;
        end
      end
      TX_POP: begin
        state_d = TX_LATCH;
      end
      default: begin
        state_d = TX_IDLE;
      end
    endcase
  end

  assign push_now = (state_q == TX_PUSH);
  assign pop_now  = (state_q == TX_POP);

  // Last byte leaving through a JTAG read
  assign tx_popped_last_o = pop_now & (tx_count_o == count_t'(1));

  jsp_byte_fifo u_tx_fifo (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .flush_i  (flush_i),
    .en_i     (push_now | pop_now),
    .push_i   (push_now),
    .data_i   (wdata_q),
    .data_o   (fifo_head),
    .avail_o  (tx_count_o),
    .free_o   ()
  );

  // Debug unit reads this register, not the FIFO head
  always_ff @(posedge PCLK) begin
    if (state_q == TX_LATCH) begin
      data_o <= fifo_head;
    end
  end

  jsp_count_sync #(
    .RESET_COUNT ('0)
  ) u_avail_sync (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .tck_i    (tck_i),
    .count_i  (tx_count_o),
    .count_o  (bytes_available_o)
  );

endmodule : jsp_host_tx_path

`default_nettype wire

/* logic/jsp_uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jsp_defines.svh"

module jsp_uart_regs
  import jsp_link_pkg::*;
  import jsp_bus_pkg::*;
(
  input  wire                   PCLK,
  input  wire                   PRESETn,
  input  wire                   psel_i,
  input  wire                   penable_i,
  input  wire                   pwrite_i,
  input  wire [`JSP_ADDR_W-1:0] paddr_i,
  input  wire byte_t            pwdata_i,
  output byte_t                 prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  input  wire byte_t            rx_data_i,
  input  wire count_t           rx_count_i,
  input  wire count_t           tx_count_i,
  input  wire                   tx_popped_last_i,
  input  wire                   rx_ack_i,
  input  wire                   tx_ack_i,
  output logic                  rx_pop_req_o,
  output logic                  tx_push_req_o,
  output logic                  rx_flush_o,
  output logic                  tx_flush_o,
  output logic                  int_o
);

  reg_addr_e   addr;
  logic        setup;
  logic        wr_access;
  logic        data_sel;
  logic        dlab;
  logic        reg_ack_q;
  logic [3:0]  ier_q;
  byte_t       lcr_q;
  byte_t       scr_q;
  byte_t       lsr;
  logic        rx_ready;
  logic        tx_not_full;
  logic        thr_arm_q;
  logic        iir_read;
  iir_code_e   iir;

  //////////////////////////////
  // APB decode
  //////////////////////////////

  assign addr      = reg_addr_e'(paddr_i);
  assign setup     = psel_i & ~penable_i;
  assign wr_access = psel_i & penable_i & pwrite_i;
  assign data_sel  = (addr == REG_DATA);
  assign dlab      = lcr_q[LCR_DLAB];

  // FIFO requests start in the setup phase
  assign rx_pop_req_o  = setup & ~pwrite_i & data_sel & ~dlab;
  assign tx_push_req_o = setup & pwrite_i & data_sel & ~dlab;

  // Plain registers answer with no wait state
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      reg_ack_q <= 1'b0;
    end else begin
      reg_ack_q <= setup & (dlab | ~data_sel);
    end
  end

  assign pready_o  = reg_ack_q | rx_ack_i | tx_ack_i;
  assign pslverr_o = 1'b0;

  //////////////////////////////
  // Writable registers
  //////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      ier_q <= '0;
      lcr_q <= '0;
      scr_q <= '0;
    end else if (wr_access) begin
      case (addr)
        REG_IER: begin
          // Locked while the divisor latch is selected
          if (!dlab) begin
            ier_q <= pwdata_i[3:0];
          end
        end
        REG_LCR: lcr_q <= pwdata_i;
        REG_SCR: scr_q <= pwdata_i;
        default: begin
        end
      endcase
    end
  end

  // FCR write flushes one or both directions
  assign rx_flush_o = wr_access & (addr == REG_IIR_FCR) & pwdata_i[FCR_RX_FLUSH];
  assign tx_flush_o = wr_access & (addr == REG_IIR_FCR) & pwdata_i[FCR_TX_FLUSH];

  //////////////////////////////
  // Status and interrupts
  //////////////////////////////

  assign rx_ready    = (rx_count_i != '0);
  assign tx_not_full = (tx_count_i != count_t'(`JSP_FIFO_DEPTH));
  assign lsr         = {1'b0, tx_not_full, tx_not_full, 4'h0, rx_ready};
  assign iir_read    = psel_i & penable_i & ~pwrite_i & (addr == REG_IIR_FCR);

  // Transmitter empty stays armed until software has seen it
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      thr_arm_q <= 1'b0;
    end else if (tx_push_req_o || tx_popped_last_i) begin
      thr_arm_q <= 1'b1;
    end else if (iir_read && !rx_ready) begin
      thr_arm_q <= 1'b0;
    end
  end

  // Receive data outranks transmitter empty
  always_comb begin
    if (rx_ready) begin
      iir = IIR_RX_DATA;
    end else if (thr_arm_q && tx_not_full) begin
      iir = IIR_THR_EMPTY;
    end else begin
      iir = IIR_NONE;
    end
  end

  assign int_o = (rx_ready & ier_q[0]) | (thr_arm_q & tx_not_full & ier_q[1]);

  // Read data
  always_comb begin
    case (addr)
      REG_DATA:    prdata_o = rx_data_i;
      REG_IER:     prdata_o = {4'h0, ier_q};
      REG_IIR_FCR: prdata_o = iir;
      REG_LCR:     prdata_o = lcr_q;
      REG_MCR:     prdata_o = MCR_VALUE;
      REG_LSR:     prdata_o = lsr;
      REG_MSR:     prdata_o = MSR_VALUE;
      REG_SCR:     prdata_o = scr_q;
      default:     prdata_o = '0;
    endcase
  end

  // No ack from any source outside an access phase
  a_pready_in_access : assert property (@(posedge PCLK) disable iff (!PRESETn)
    pready_o |-> (psel_i && penable_i));

endmodule : jsp_uart_regs

`default_nettype wire

/* logic/jsp_apb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jsp_defines.svh"

module jsp_apb_bridge
  import jsp_link_pkg::*;
(
  input  wire                   PCLK,
  input  wire                   PRESETn,
  // APB slave
  input  wire                   psel_i,
  input  wire                   penable_i,
  input  wire                   pwrite_i,
  input  wire [`JSP_ADDR_W-1:0] paddr_i,
  input  wire byte_t            pwdata_i,
  output byte_t                 prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  output logic                  int_o,
  // Debug unit side
  input  wire                   tck_i,
  input  wire                   wr_strobe_i,
  input  wire byte_t            data_i,
  input  wire                   rd_strobe_i,
  output byte_t                 data_o,
  output count_t                bytes_available_o,
  output count_t                bytes_free_o
);

  logic   rx_pop_req;
  logic   tx_push_req;
  logic   rx_flush;
  logic   tx_flush;
  logic   rx_ack;
  logic   tx_ack;
  logic   tx_popped_last;
  byte_t  rx_data;
  count_t rx_count;
  count_t tx_count;

  // JTAG to APB
  jsp_host_rx_path u_rx_path (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .tck_i        (tck_i),
    .wr_strobe_i  (wr_strobe_i),
    .data_i       (data_i),
    .pop_req_i    (rx_pop_req),
    .flush_i      (rx_flush),
    .ack_o        (rx_ack),
    .rx_data_o    (rx_data),
    .rx_count_o   (rx_count),
    .bytes_free_o (bytes_free_o)
  );

  // APB to JTAG
  jsp_host_tx_path u_tx_path (
    .PCLK              (PCLK),
    .PRESETn           (PRESETn),
    .tck_i             (tck_i),
    .rd_strobe_i       (rd_strobe_i),
    .push_req_i        (tx_push_req),
    .pwdata_i          (pwdata_i),
    .flush_i           (tx_flush),
    .ack_o             (tx_ack),
    .tx_count_o        (tx_count),
    .tx_popped_last_o  (tx_popped_last),
    .data_o            (data_o),
    .bytes_available_o (bytes_available_o)
  );

  jsp_uart_regs u_regs (
    .PCLK             (PCLK),
    .PRESETn          (PRESETn),
    .psel_i           (psel_i),
    .penable_i        (penable_i),
    .pwrite_i         (pwrite_i),
    .paddr_i          (paddr_i),
    .pwdata_i         (pwdata_i),
    .prdata_o         (prdata_o),
    .pready_o         (pready_o),
    .pslverr_o        (pslverr_o),
    .rx_data_i        (rx_data),
    .rx_count_i       (rx_count),
    .tx_count_i       (tx_count),
    .tx_popped_last_i (tx_popped_last),
    .rx_ack_i         (rx_ack),
    .tx_ack_i         (tx_ack),
    .rx_pop_req_o     (rx_pop_req),
    .tx_push_req_o    (tx_push_req),
    .rx_flush_o       (rx_flush),
    .tx_flush_o       (tx_flush),
    .int_o            (int_o)
  );

endmodule : jsp_apb_bridge

`default_nettype wire

/* tests/jsp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "jsp_defines.svh"

module jsp_tb
  import jsp_link_pkg::*;
  import jsp_bus_pkg::*;
();

  // All tests together take roughly 1500 PCLK cycles
  localparam int unsigned TIMEOUT_CYCLES = 4000;
  // A single pop may wait one extra cycle behind a JTAG push
  localparam int unsigned APB_POLL_LIMIT = 8;
  // Two count handshakes plus a strobe crossing fit well inside this
  localparam int unsigned TCK_POLL_LIMIT = 60;
  localparam int unsigned LSR_POLL_LIMIT = 20;
  localparam logic [31:0] LCG_SEED       = 32'd39162;

  logic                   PCLK;
  logic                   PRESETn;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  logic [`JSP_ADDR_W-1:0] paddr_i;
  byte_t                  pwdata_i;
  byte_t                  prdata_o;
  logic                   pready_o;
  logic                   pslverr_o;
  logic                   int_o;
  logic                   tck_i;
  logic                   wr_strobe_i;
  byte_t                  data_i;
  logic                   rd_strobe_i;
  byte_t                  data_o;
  count_t                 bytes_available_o;
  count_t                 bytes_free_o;

  logic [31:0]            lcg_state;
  string                  test_name;
  int unsigned            cycle_count;
  byte_t                  sent [16];

  jsp_apb_bridge u_jsp_apb_bridge (
    .PCLK              (PCLK),
    .PRESETn           (PRESETn),
    .psel_i            (psel_i),
    .penable_i         (penable_i),
    .pwrite_i          (pwrite_i),
    .paddr_i           (paddr_i),
    .pwdata_i          (pwdata_i),
    .prdata_o          (prdata_o),
    .pready_o          (pready_o),
    .pslverr_o         (pslverr_o),
    .int_o             (int_o),
    .tck_i             (tck_i),
    .wr_strobe_i       (wr_strobe_i),
    .data_i            (data_i),
    .rd_strobe_i       (rd_strobe_i),
    .data_o            (data_o),
    .bytes_available_o (bytes_available_o),
    .bytes_free_o      (bytes_free_o)
  );

  // Unrelated clocks whose rising edges never coincide
  always #50 PCLK = ~PCLK;
  always #35 tck_i = ~tck_i;

  //////////////////////////////
  // Helpers and checks
  //////////////////////////////

  function automatic byte_t next_random_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_byte(input string what, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected 0x%02h, actual 0x%02h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string what, input count_t exp, input count_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  //////////////////////////////
  // APB driver
  //////////////////////////////

  // Setup for one cycle, then hold the access phase until PREADY
  task automatic apb_access(input logic write, input reg_addr_e addr, input byte_t wdata,
                            output byte_t rdata);
    int polls;
    polls = 0;
    @(posedge PCLK);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge PCLK);
    penable_i <= 1'b1;
    // Sample mid cycle where PREADY and PRDATA are settled
    @(negedge PCLK);
    while (!pready_o) begin
      polls = polls + 1;
      if (polls > APB_POLL_LIMIT) begin
        $display("APB access to offset %0d in test %s never got PREADY", addr, test_name);
        abort_run();
      end
      @(negedge PCLK);
    end
    check_flag("pslverr_o", 1'b0, pslverr_o);
    rdata = prdata_o;
    @(posedge PCLK);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic apb_write(input reg_addr_e addr, input byte_t wdata);
    byte_t unused;
    apb_access(1'b1, addr, wdata, unused);
  endtask

  task automatic apb_read(input reg_addr_e addr, output byte_t rdata);
    apb_access(1'b0, addr, 8'h00, rdata);
  endtask

  task automatic expect_reg(input string what, input reg_addr_e addr, input byte_t exp);
    byte_t rd;
    apb_read(addr, rd);
    check_byte(what, exp, rd);
  endtask

  //////////////////////////////
  // JTAG driver
  //////////////////////////////

  task automatic wait_bytes_available(input count_t exp);
    int polls;
    polls = 0;
    @(negedge tck_i);
    while (bytes_available_o !== exp) begin
      polls = polls + 1;
      if (polls > TCK_POLL_LIMIT) begin
        $display("In test %s bytes_available_o stayed at %0d and never reached %0d",
                 test_name, bytes_available_o, exp);
        abort_run();
      end
      @(negedge tck_i);
    end
  endtask

  task automatic wait_bytes_free(input count_t exp);
    int polls;
    polls = 0;
    @(negedge tck_i);
    while (bytes_free_o !== exp) begin
      polls = polls + 1;
      if (polls > TCK_POLL_LIMIT) begin
        $display("In test %s bytes_free_o stayed at %0d and never reached %0d",
                 test_name, bytes_free_o, exp);
        abort_run();
      end
      @(negedge tck_i);
    end
  endtask

  // One strobe per byte, then wait until the free count shows the push
  task automatic jtag_write(input byte_t b, input count_t free_after);
    @(posedge tck_i);
    wr_strobe_i <= 1'b1;
    data_i      <= b;
    @(posedge tck_i);
    wr_strobe_i <= 1'b0;
    wait_bytes_free(free_after);
  endtask

  // Head is valid once the count reflects the previous pop
  task automatic jtag_read(input count_t avail_now, input byte_t exp);
    wait_bytes_available(avail_now);
    @(negedge PCLK);
    check_byte("data_o", exp, data_o);
    @(posedge tck_i);
    rd_strobe_i <= 1'b1;
    @(posedge tck_i);
    rd_strobe_i <= 1'b0;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset();
    test_name = "reset";
    expect_reg("IER", REG_IER, 8'h00);
    expect_reg("LCR", REG_LCR, 8'h00);
    expect_reg("IIR", REG_IIR_FCR, IIR_NONE);
    expect_reg("LSR", REG_LSR, 8'h60);
    @(negedge PCLK);
    check_flag("int_o", 1'b0, int_o);
    @(negedge tck_i);
    check_count("bytes_available_o", count_t'(0), bytes_available_o);
    check_count("bytes_free_o", count_t'(`JSP_FIFO_DEPTH), bytes_free_o);
  endtask

  task automatic test_registers();
    byte_t val;
    byte_t rd;
    test_name = "registers";
    val = next_random_byte();
    apb_write(REG_SCR, val);
    expect_reg("SCR", REG_SCR, val);
    apb_write(REG_LCR, 8'h1b);
    expect_reg("LCR", REG_LCR, 8'h1b);
    // With the divisor latch selected IER is locked and the data offset bypasses the FIFOs
    apb_write(REG_LCR, 8'h83);
    expect_reg("LCR with DLAB", REG_LCR, 8'h83);
    apb_write(REG_IER, 8'h0f);
    expect_reg("IER while locked", REG_IER, 8'h00);
    apb_write(REG_DATA, 8'hee);
    // A real push would have armed transmitter empty
    expect_reg("IIR after DLAB data write", REG_IIR_FCR, IIR_NONE);
    expect_reg("LSR after DLAB data write", REG_LSR, 8'h60);
    repeat (20) @(negedge tck_i);
    check_count("bytes_available_o after DLAB write", count_t'(0), bytes_available_o);
    // Receive byte stays queued through a data read while the latch is selected
    val = next_random_byte();
    jtag_write(val, count_t'(7));
    apb_read(REG_DATA, rd);
    expect_reg("LSR after DLAB data read", REG_LSR, 8'h61);
    apb_write(REG_LCR, 8'h00);
    expect_reg("LCR cleared", REG_LCR, 8'h00);
    expect_reg("RBR after DLAB data read", REG_DATA, val);
    expect_reg("LSR after RBR read", REG_LSR, 8'h60);
    wait_bytes_free(count_t'(`JSP_FIFO_DEPTH));
  endtask

  task automatic test_apb_to_jtag();
    test_name = "apb_to_jtag";
    for (int i = 0; i < 5; i++) begin
      sent[i] = next_random_byte();
      apb_write(REG_DATA, sent[i]);
    end
    wait_bytes_available(count_t'(5));
    for (int i = 0; i < 5; i++) begin
      jtag_read(count_t'(5 - i), sent[i]);
    end
    wait_bytes_available(count_t'(0));
    // Nine writes so the last one lands on a full FIFO
    for (int i = 0; i < 9; i++) begin
      sent[i] = next_random_byte();
      apb_write(REG_DATA, sent[i]);
    end
    wait_bytes_available(count_t'(`JSP_FIFO_DEPTH));
    expect_reg("LSR with full transmit FIFO", REG_LSR, 8'h00);
    for (int i = 0; i < 8; i++) begin
      jtag_read(count_t'(8 - i), sent[i]);
    end
    wait_bytes_available(count_t'(0));
  endtask

  task automatic test_jtag_to_apb();
    byte_t rd;
    int    polls;
    test_name = "jtag_to_apb";
    for (int i = 0; i < 6; i++) begin
      sent[i] = next_random_byte();
      jtag_write(sent[i], count_t'(7 - i));
    end
    polls = 0;
    apb_read(REG_LSR, rd);
    while (!rd[0]) begin
      polls = polls + 1;
      if (polls > LSR_POLL_LIMIT) begin
        $display("LSR data ready never came up after the JTAG writes");
        abort_run();
      end
      apb_read(REG_LSR, rd);
    end
    check_byte("LSR with receive data", 8'h61, rd);
    wait_bytes_free(count_t'(2));
    for (int i = 0; i < 6; i++) begin
      expect_reg("RBR", REG_DATA, sent[i]);
    end
    expect_reg("LSR after reads", REG_LSR, 8'h60);
    wait_bytes_free(count_t'(`JSP_FIFO_DEPTH));
  endtask

  task automatic test_interrupts();
    byte_t val;
    test_name = "interrupts";
    apb_write(REG_IER, 8'h01);
    val = next_random_byte();
    jtag_write(val, count_t'(7));
    @(negedge PCLK);
    check_flag("int_o on receive data", 1'b1, int_o);
    expect_reg("IIR receive data", REG_IIR_FCR, IIR_RX_DATA);
    expect_reg("RBR", REG_DATA, val);
    @(negedge PCLK);
    check_flag("int_o after receive read", 1'b0, int_o);
    wait_bytes_free(count_t'(`JSP_FIFO_DEPTH));
    // Transmitter empty once the last byte leaves through JTAG
    apb_write(REG_IER, 8'h02);
    val = next_random_byte();
    apb_write(REG_DATA, val);
    // Seen right after the push so only the drain can arm it again
    expect_reg("IIR after push", REG_IIR_FCR, IIR_THR_EMPTY);
    expect_reg("IIR before drain", REG_IIR_FCR, IIR_NONE);
    @(negedge PCLK);
    check_flag("int_o before drain", 1'b0, int_o);
    jtag_read(count_t'(1), val);
    wait_bytes_available(count_t'(0));
    @(negedge PCLK);
    check_flag("int_o on transmitter empty", 1'b1, int_o);
    expect_reg("IIR transmitter empty", REG_IIR_FCR, IIR_THR_EMPTY);
    expect_reg("IIR after it was seen", REG_IIR_FCR, IIR_NONE);
    @(negedge PCLK);
    check_flag("int_o after IIR read", 1'b0, int_o);
  endtask

  task automatic test_flush();
    test_name = "flush";
    apb_write(REG_IER, 8'h00);
    for (int i = 0; i < 3; i++) begin
      jtag_write(next_random_byte(), count_t'(7 - i));
    end
    for (int i = 0; i < 4; i++) begin
      apb_write(REG_DATA, next_random_byte());
    end
    wait_bytes_available(count_t'(4));
    expect_reg("LSR before flush", REG_LSR, 8'h61);
    // FCR bits 1 and 2 clear both directions
    apb_write(REG_IIR_FCR, 8'h06);
    expect_reg("LSR after flush", REG_LSR, 8'h60);
    wait_bytes_available(count_t'(0));
    wait_bytes_free(count_t'(`JSP_FIFO_DEPTH));
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////

  initial begin
    PCLK        = 1'b0;
    tck_i       = 1'b0;
    PRESETn     = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    wr_strobe_i = 1'b0;
    data_i      = '0;
    rd_strobe_i = 1'b0;
    lcg_state   = LCG_SEED;
    test_name   = "init";
    repeat (2) @(posedge PCLK);
    PRESETn <= 1'b1;
    test_reset();
    test_registers();
    test_apb_to_jtag();
    test_jtag_to_apb();
    test_interrupts();
    test_flush();
    $display("SIMULATION PASSED");
    $finish;
  end

  // Watchdog on PCLK
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge PCLK);
      cycle_count = cycle_count + 1;
    end
    $display("Run did not finish within %0d PCLK cycles, stuck in test %s",
             TIMEOUT_CYCLES, test_name);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule : jsp_tb

`default_nettype wire

/* compile.f */
+incdir+include
logic/jsp_link_pkg.sv
logic/jsp_bus_pkg.sv
logic/jsp_byte_fifo.sv
logic/jsp_strobe_sync.sv
logic/jsp_count_sync.sv
logic/jsp_host_rx_path.sv
logic/jsp_host_tx_path.sv
logic/jsp_uart_regs.sv
logic/jsp_apb_bridge.sv
tests/jsp_tb.sv
